/* hw/pow_macros.svh */
`ifndef POW_MACROS_SVH
`define POW_MACROS_SVH

// operand and power width
`define POW_W 8

// entries in each queue
`define POW_FIFO_DEPTH 4

// APB register byte offsets
`define POW_ADDR_CTRL    12'h000
`define POW_ADDR_OPERAND 12'h004
`define POW_ADDR_RESULT  12'h008
`define POW_ADDR_STATUS  12'h00C

`endif

/* hw/pow_pkg.sv */
`include "pow_macros.svh"

package pow_pkg;

    // one operand word
    typedef logic [`POW_W - 1:0] operand_t;

    // operand and its fifth power, operand in the upper word
    typedef struct packed {
        operand_t operand;  // prdata 15:8 on a RESULT read
        operand_t power;    // prdata 7:0
    } result_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_drain
    } seq_state_t;

endpackage

/* hw/pow_5_pipe.sv */
`timescale 1ns/1ns

module pow_5_pipe
    import pow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clk_en,
    input  logic       n_vld,
    input  operand_t   n,
    output logic [3:0] res_vld,
    output result_t    res
);

    logic [5:1] vld_q;        // valid per stage, stage 1 first
    operand_t   n_q   [1:5];  // operand carried alongside the product
    operand_t   mul_q [2:5];  // running product, n^2 at stage 2

    ////////////////////////////////////////////////////////////////////////////
    // valid chain

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (clk_en) begin
            vld_q <= {vld_q[4:1], n_vld};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data path, each stage multiplies by the carried operand

    always_ff @(posedge clk) begin
        if (clk_en) begin
            n_q[1]   <= n;
            n_q[2]   <= n_q[1];
            mul_q[2] <= n_q[1] * n_q[1];         // square
            for (int k = 3; k <= 5; k++) begin
                n_q[k]   <= n_q[k - 1];
                mul_q[k] <= mul_q[k - 1] * n_q[k - 1];  // truncated to operand width
            end
        end
    end

    // stage 2 in the top bit of occupancy, stage 5 in bit 0
    assign res_vld = {vld_q[2], vld_q[3], vld_q[4], vld_q[5]};

    assign res.operand = n_q[5];
    assign res.power   = mul_q[5];

    // an operand offered on a frozen edge would never reach the final stage
    n_vld_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        n_vld |-> clk_en
    );

endmodule

/* hw/pow_fifo.sv */
`include "pow_macros.svh"
`timescale 1ns/1ns

module pow_fifo #(
    parameter type payload_t = logic [`POW_W - 1:0]
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic       pop,
    input  payload_t   din,
    output payload_t   dout,
    output logic [2:0] count,
    output logic       full,
    output logic       empty
);

    localparam int depth = `POW_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);

    payload_t           mem [depth];
    logic [ptr_w - 1:0] wr_ptr;
    logic [ptr_w - 1:0] rd_ptr;

    assign full  = (count == 3'(depth));
    assign empty = (count == 3'd0);
    assign dout  = mem[rd_ptr];              // head entry

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + {2'b0, push && !full} - {2'b0, pop && !empty};
        end
    end

    // producers and consumers are expected to honour full and empty
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(push && full));

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* hw/pow_credit_cnt.sv */
`include "pow_macros.svh"
`timescale 1ns/1ns

module pow_credit_cnt (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       issue,         // operand entered the pipeline
    input  logic       retire,        // result landed in the result queue
    input  logic       release_slot,  // result read by software
    output logic [2:0] in_flight,
    output logic       can_issue
);

    localparam int depth = `POW_FIFO_DEPTH;

    logic [2:0] free_slots;  // result slots neither filled nor reserved

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight  <= '0;
            free_slots <= 3'(depth);
        end else begin
            in_flight  <= in_flight + {2'b0, issue} - {2'b0, retire};
            // retire keeps the reservation, the slot is now filled
            free_slots <= free_slots - {2'b0, issue} + {2'b0, release_slot};
        end
    end

    assign can_issue = (free_slots != 3'd0);

    in_flight_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) in_flight <= 3'(depth));

endmodule

/* hw/pow_seq_fsm.sv */
`timescale 1ns/1ns

module pow_seq_fsm
    import pow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       operand_empty,
    input  logic       can_issue,
    input  logic [2:0] in_flight,
    output logic       operand_pop,
    output logic       n_vld,
    output logic       clk_en,
    output logic       busy
);

    seq_state_t state;
    seq_state_t state_nxt;
    logic       can_go;
    logic       issue;

    assign can_go = enable && !operand_empty && can_issue;
    assign issue  = (state == seq_run) && can_go;

    always_comb begin
        state_nxt = state;
        case (state)
            seq_idle:  if (can_go) state_nxt = seq_run;
            seq_run:   if (!can_go) state_nxt = (in_flight != 3'd0) ? seq_drain : seq_idle;
            seq_drain: begin
                if (can_go) begin
                    state_nxt = seq_run;
                end else if (in_flight == 3'd0) begin
                    state_nxt = seq_idle;      // everything has landed
                end
            end
            default:   state_nxt = seq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) state <= seq_idle;
        else        state <= state_nxt;
    end

    assign operand_pop = issue;
    assign n_vld       = issue;
    assign clk_en      = enable && (issue || in_flight != 3'd0);  // cleared enable freezes
    assign busy        = (state != seq_idle);

endmodule

/* hw/pow_apb_regs.sv */
`include "pow_macros.svh"
`timescale 1ns/1ns

module pow_apb_regs
    import pow_pkg::*;
(
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        clk,
    input  logic        rst_n,
    input  logic        operand_full,
    input  logic        result_empty,
    input  result_t     result_head,
    input  logic [2:0]  operand_count,
    input  logic [2:0]  result_count,
    input  logic [3:0]  res_vld,
    input  logic        busy,
    output logic        enable,
    output logic        operand_push,
    output logic        result_pop,
    output operand_t    operand_data
);

    logic        setup;
    logic        access;
    logic [31:0] rd_data;
    logic        err_nxt;
    logic        err_q;   // error decided in setup, shown in access

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // decode during setup so data and error are registered for the access phase
    always_comb begin
        rd_data = '0;
        err_nxt = 1'b0;
        case (paddr)
            `POW_ADDR_CTRL:    rd_data = {31'b0, enable};
            `POW_ADDR_OPERAND: if (pwrite) err_nxt = operand_full;
            `POW_ADDR_RESULT: begin
                if (!pwrite) begin
                    if (result_empty) err_nxt = 1'b1;          // data stays 0
                    else              rd_data = {16'b0, result_head};
                end
            end
            `POW_ADDR_STATUS:  rd_data = {19'b0, busy, res_vld, 1'b0, result_count,
                                          1'b0, operand_count};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= 1'b0;
            err_q  <= 1'b0;
            prdata <= '0;
        end else begin
            err_q <= setup && err_nxt;
            if (setup && !pwrite) prdata <= rd_data;
            if (access && pwrite && paddr == `POW_ADDR_CTRL) enable <= pwdata[0];
        end
    end

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = err_q;

    // side effects only in the access phase, and only without error
    assign operand_push = access && pwrite && paddr == `POW_ADDR_OPERAND && !err_q;
    assign result_pop   = access && !pwrite && paddr == `POW_ADDR_RESULT && !err_q;
    assign operand_data = pwdata[`POW_W - 1:0];

endmodule

/* hw/pow_top.sv */
`timescale 1ns/1ns

module pow_top
    import pow_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic       enable;
    logic       operand_push;
    logic       operand_pop;
    operand_t   operand_data;
    operand_t   operand_head;
    logic [2:0] operand_count;
    logic       operand_full;
    logic       operand_empty;
    logic       result_push;
    logic       result_pop;
    result_t    result_head;
    logic [2:0] result_count;
    logic       result_empty;
    logic [2:0] in_flight;
    logic       can_issue;
    logic       n_vld;
    logic       clk_en;
    logic       busy;
    logic [3:0] res_vld;
    result_t    res;

    // final stage leaves on an enabled edge, so a frozen result is pushed once
    assign result_push = res_vld[0] && clk_en;

    pow_apb_regs u_apb_regs (
        .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .clk (clk), .rst_n (rst_n),
        .operand_full (operand_full), .result_empty (result_empty),
        .result_head (result_head), .operand_count (operand_count),
        .result_count (result_count), .res_vld (res_vld), .busy (busy),
        .enable (enable), .operand_push (operand_push), .result_pop (result_pop),
        .operand_data (operand_data)
    );

    pow_fifo #(.payload_t (operand_t)) u_operand_q (
        .clk (clk), .rst_n (rst_n), .push (operand_push), .pop (operand_pop),
        .din (operand_data), .dout (operand_head), .count (operand_count),
        .full (operand_full), .empty (operand_empty)
    );

    pow_fifo #(.payload_t (result_t)) u_result_q (
        .clk (clk), .rst_n (rst_n), .push (result_push), .pop (result_pop),
        .din (res), .dout (result_head), .count (result_count),
        .full (), .empty (result_empty)  // credit keeps pushes off a full queue
    );

    pow_credit_cnt u_credit_cnt (
        .clk (clk), .rst_n (rst_n), .issue (n_vld), .retire (result_push),
        .release_slot (result_pop), .in_flight (in_flight), .can_issue (can_issue)
    );

    pow_seq_fsm u_seq_fsm (
        .clk (clk), .rst_n (rst_n), .enable (enable), .operand_empty (operand_empty),
        .can_issue (can_issue), .in_flight (in_flight), .operand_pop (operand_pop),
        .n_vld (n_vld), .clk_en (clk_en), .busy (busy)
    );

    pow_5_pipe u_pipe (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en), .n_vld (n_vld),
        .n (operand_head), .res_vld (res_vld), .res (res)
    );

endmodule

/* test/tb_pow_top.sv */
`include "pow_macros.svh"
`timescale 1ns/1ns

module tb_pow_top;

    localparam int poll_limit  = 200;  // cycles allowed per poll line
    localparam int ready_limit = 16;   // cycles allowed for pready

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int cycle = 0;
    int mismatches;
    int timeouts;
    int file_errors;

    pow_top u_pow_top (
        .clk (clk), .rst_n (rst_n), .psel (psel), .penable (penable),
        .pwrite (pwrite), .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
        .pready (pready), .pslverr (pslverr)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB access, inputs change on the falling edge

    task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;                   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;                   // access phase
        while (!pready && waited < ready_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("slave never raised pready at address %h", addr);
            timeouts++;
        end
        rdata = prdata;                   // stable since the setup edge
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // reads STATUS until the result count matches
    task automatic poll_result_count(input logic [8*16-1:0] name, input logic [2:0] exp_cnt);
        logic [31:0] status;
        logic        err;
        logic        done;
        int          start;
        done  = 1'b0;
        start = cycle;
        while (!done && cycle - start < poll_limit) begin
            apb_xfer(1'b0, `POW_ADDR_STATUS, 32'h0, status, err);
            if (status[6:4] > 3'd4) begin
                $display("Fail %0s: expected result count at most 4, actual %0d",
                         name, status[6:4]);
                mismatches++;
            end
            if (err !== 1'b0) begin
                $display("Fail %0s: expected pslverr 0, actual %b", name, err);
                mismatches++;
            end
            done = (status[6:4] == exp_cnt);
        end
        if (!done) begin
            $display("result count for %0s did not reach %0d within %0d cycles",
                     name, exp_cnt, poll_limit);
            timeouts++;
        end
    endtask

    // carries out one line of the golden file
    task automatic run_line(input logic [7:0] op, input logic [11:0] addr,
                            input logic [31:0] data, input logic exp_err,
                            input logic [8*16-1:0] name);
        logic [31:0] rdata;
        logic        err;
        case (op)
            "W": begin
                apb_xfer(1'b1, addr, data, rdata, err);
                if (err !== exp_err) begin
                    $display("Fail %0s: expected pslverr %b, actual %b", name, exp_err, err);
                    mismatches++;
                end
            end
            "R": begin
                apb_xfer(1'b0, addr, 32'h0, rdata, err);
                if (rdata !== data) begin
                    $display("Fail %0s: expected %h, actual %h", name, data, rdata);
                    mismatches++;
                end
                if (err !== exp_err) begin
                    $display("Fail %0s: expected pslverr %b, actual %b", name, exp_err, err);
                    mismatches++;
                end
            end
            "P": poll_result_count(name, data[2:0]);
            default: begin
                $display("unknown operation in golden line %0s", name);
                file_errors++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reset, then one transaction per golden line

    initial begin
        int               fd;
        int               code;
        int               exp_err;
        logic [7:0]       op;
        logic [11:0]      addr;
        logic [31:0]      data;
        logic [8*16-1:0]  name;
        logic [8*128-1:0] skip_line;

        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 12'h0;
        pwdata      = 32'h0;
        mismatches  = 0;
        timeouts    = 0;
        file_errors = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("test/pow_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/pow_golden.txt");
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) break;
                if (op == "#") begin
                    code = $fgets(skip_line, fd);   // comment line
                end else begin
                    code = $fscanf(fd, "%h %h %d %s", addr, data, exp_err, name);
                    if (code != 4) begin
                        $display("golden file line is incomplete");
                        file_errors++;
                        break;
                    end
                    run_line(op, addr, data, exp_err[0], name);
                end
            end
            $fclose(fd);
        end

        $display("mismatches %0d, timeouts %0d, file errors %0d",
                 mismatches, timeouts, file_errors);
        if (mismatches == 0 && timeouts == 0 && file_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/pow_pkg.sv
hw/pow_5_pipe.sv
hw/pow_fifo.sv
hw/pow_credit_cnt.sv
hw/pow_seq_fsm.sv
hw/pow_apb_regs.sv
hw/pow_top.sv
test/tb_pow_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the power engine testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_pow_top \
    --Mdir obj_dir -o sim_pow
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_pow > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
    exit 1
fi
exit 0

/* test/pow_golden.txt */
# op addr data err name
# W write, R read and compare data, P poll STATUS until result count equals data
R 00C 00000000 0 reset_status
R 000 00000000 0 reset_ctrl
W 000 00000001 0 enable_on
W 004 00000003 0 single_wr
P 00C 00000001 0 single_poll
R 008 000003F3 0 single_rd
W 004 00000006 0 burst_wr0
W 004 00000009 0 burst_wr1
W 004 00000011 0 burst_wr2
W 004 00000013 0 burst_wr3
P 00C 00000004 0 burst_poll
W 004 000000FF 0 bp_wr4
W 004 00000001 0 bp_wr5
R 00C 00000042 0 bp_status
R 008 00000660 0 burst_rd0
R 008 000009A9 0 burst_rd1
R 008 00001151 0 burst_rd2
R 008 00001343 0 burst_rd3
P 00C 00000002 0 bp_poll
R 008 0000FFFF 0 bp_rd4
R 008 00000101 0 bp_rd5
R 008 00000000 1 empty_rd
W 000 00000000 0 freeze_off
W 004 00000004 0 freeze_wr
R 00C 00000001 0 freeze_status
W 004 0000000B 0 fill_wr1
W 004 00000003 0 fill_wr2
W 004 00000002 0 fill_wr3
W 004 00000055 1 full_wr
R 00C 00000004 0 full_status
W 000 00000001 0 freeze_on
P 00C 00000004 0 freeze_poll
R 008 00000400 0 freeze_rd0
R 008 00000B1B 0 freeze_rd1
R 008 000003F3 0 freeze_rd2
R 008 00000220 0 freeze_rd3
